// ==== Bender.yml ====
package:
  name: io_top

sources:
  - include_dirs:
      - include
    files:
      - rtl/io_pkg.sv
      - rtl/seg_decoder.sv
      - rtl/fan_pwm.sv
      - rtl/tx_fifo.sv
      - rtl/uart_tx.sv
      - rtl/io_controller.sv
      - rtl/io_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - test/io_top_properties.sv
      - test/io_top_tb.sv

// ==== include/io_defines.svh ====
`ifndef IO_DEFINES_SVH
`define IO_DEFINES_SVH

// Serial timing
`define IO_BAUD_DIV 8

// Transmit buffer of 4 entries
`define IO_FIFO_DEPTH_LOG2 2

// Fan PWM counter width, period 64
`define IO_PWM_BITS 6

// Register values after reset
`define IO_FAN_RESET 32
`define IO_SEG_RESET 32'h0000_0000

// Address pages, adr_i[15:12]
`define IO_PAGE_SYS   4'h0
`define IO_PAGE_SWLED 4'h1
`define IO_PAGE_UART  4'h2

`endif

// ==== io_top.f ====
+incdir+include
rtl/io_pkg.sv
rtl/seg_decoder.sv
rtl/fan_pwm.sv
rtl/tx_fifo.sv
rtl/uart_tx.sv
rtl/io_controller.sv
rtl/io_top.sv
test/io_top_properties.sv
test/io_top_tb.sv

// ==== rtl/fan_pwm.sv ====
`default_nettype none

`include "io_defines.svh"

module fan_pwm (
  input  logic              clk_i,
  input  logic              rst_i,
  input  io_pkg::pwm_duty_t duty_i,
  output logic              fan_o
);

  logic [`IO_PWM_BITS-1:0] cnt_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;                // Free running, wraps every period
    end
  end

  // Duty at or above the period keeps the fan fully on
  assign fan_o = ({1'b0, cnt_q} < duty_i);

endmodule

`default_nettype wire

// ==== rtl/io_controller.sv ====
`default_nettype none

`include "io_defines.svh"

module io_controller (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         cyc_i,
  input  logic                         stb_i,
  input  logic                         we_i,
  input  io_pkg::io_addr_t             adr_i,
  input  io_pkg::io_word_t             dat_i,
  input  io_pkg::io_byte_sel_t         sel_i,
  output io_pkg::io_word_t             dat_o,
  output logic                         ack_o,
  input  io_pkg::sw_t                  sw_i,
  output io_pkg::led_t                 led_o,
  output io_pkg::io_word_t             seg_word_o,
  output io_pkg::pwm_duty_t            fan_duty_o,
  output logic                         push_o,
  output io_pkg::io_byte_t             push_data_o,
  input  logic [`IO_FIFO_DEPTH_LOG2:0] fifo_count_i,
  input  logic                         uart_busy_i
);

  import io_pkg::*;

  localparam logic [`IO_FIFO_DEPTH_LOG2:0] FIFO_DEPTH = 1 << `IO_FIFO_DEPTH_LOG2;

  bus_state_e state_q;
  io_page_t   page;
  logic       fifo_full;
  logic       uart_write;
  io_word_t   seg_merged;
  io_word_t   status_word;
  io_word_t   read_word;

  assign page       = adr_i[15:12];
  assign fifo_full  = (fifo_count_i == FIFO_DEPTH);
  assign uart_write = we_i && (page == `IO_PAGE_UART);

  // Byte-lane merge for segment writes
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      seg_merged[8*i +: 8] = sel_i[i] ? dat_i[8*i +: 8] : seg_word_o[8*i +: 8];
    end
  end

  always_comb begin
    status_word        = '0;
    status_word[0]     = uart_busy_i;
    status_word[1]     = fifo_full;
    status_word[15:8]  = 8'(fifo_count_i);
  end

  always_comb begin
    case (page)
      `IO_PAGE_SYS:   read_word = adr_i[0] ? io_word_t'(fan_duty_o) : seg_word_o;
      `IO_PAGE_SWLED: read_word = io_word_t'(sw_i);
      `IO_PAGE_UART:  read_word = status_word;
      default:        read_word = '0;           // Unmapped pages
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q    <= BUS_IDLE;
      ack_o      <= 1'b0;
      push_o     <= 1'b0;
      led_o      <= '0;
      seg_word_o <= `IO_SEG_RESET;
      fan_duty_o <= `IO_FAN_RESET;
    end else begin
      ack_o  <= 1'b0;
      push_o <= 1'b0;
      case (state_q)
        BUS_IDLE: begin
          if (cyc_i && stb_i && !ack_o) begin   // Skip the cycle that still holds the old ack
            state_q <= BUS_BUSY;
          end
        end
        BUS_BUSY: begin
          if (uart_write) begin
            if (!fifo_full) begin               // Otherwise wait for a pop
              push_o  <= 1'b1;
              state_q <= BUS_DONE;
            end
          end else begin
            state_q <= BUS_DONE;
            if (we_i) begin
              case (page)
                `IO_PAGE_SYS: begin
                  if (adr_i[0]) begin
                    fan_duty_o <= dat_i[`IO_PWM_BITS:0];
                  end else begin
                    seg_word_o <= seg_merged;
                  end
                end
                `IO_PAGE_SWLED: led_o <= dat_i[8:0];
                default: ;
              endcase
            end
          end
        end
        BUS_DONE: begin
          ack_o   <= 1'b1;
          state_q <= BUS_IDLE;
        end
        default: state_q <= BUS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == BUS_BUSY && !we_i) begin
      dat_o <= read_word;
    end
    if (state_q == BUS_BUSY && uart_write && !fifo_full) begin
      push_data_o <= dat_i[7:0];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/io_pkg.sv ====
`default_nettype none

`include "io_defines.svh"

package io_pkg;

  typedef logic [31:0] io_word_t;
  typedef logic [15:0] io_addr_t;
  typedef logic [3:0]  io_page_t;      // adr_i[15:12]
  typedef logic [3:0]  io_byte_sel_t;
  typedef logic [7:0]  io_byte_t;
  typedef logic [6:0]  seg_t;          // g down to a
  typedef logic [8:0]  led_t;
  typedef logic [15:0] sw_t;

  // Extra bit so that full-on fits
  typedef logic [`IO_PWM_BITS:0] pwm_duty_t;

  typedef enum logic [1:0] {
    BUS_IDLE,
    BUS_BUSY,
    BUS_DONE
  } bus_state_e;

  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

endpackage

`default_nettype wire

// ==== rtl/io_top.sv ====
`default_nettype none

`include "io_defines.svh"

module io_top (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 cyc_i,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  io_pkg::io_addr_t     adr_i,
  input  io_pkg::io_word_t     dat_i,
  input  io_pkg::io_byte_sel_t sel_i,
  output io_pkg::io_word_t     dat_o,
  output logic                 ack_o,
  input  io_pkg::sw_t          sw_i,
  output io_pkg::led_t         led_o,
  output logic                 tx_o,
  output logic                 fan_o,
  output io_pkg::seg_t         hex0_o,
  output io_pkg::seg_t         hex1_o,
  output io_pkg::seg_t         hex2_o,
  output io_pkg::seg_t         hex3_o,
  output io_pkg::seg_t         hex4_o,
  output io_pkg::seg_t         hex5_o,
  output io_pkg::seg_t         hex6_o,
  output io_pkg::seg_t         hex7_o
);

  import io_pkg::*;

  io_word_t                     seg_word;
  pwm_duty_t                    fan_duty;
  logic                         push;
  io_byte_t                     push_data;
  logic [`IO_FIFO_DEPTH_LOG2:0] fifo_count;
  logic                         fifo_empty;
  io_byte_t                     fifo_head;
  logic                         pop;
  logic                         uart_busy;

  io_controller io_controller_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cyc_i        (cyc_i),
    .stb_i        (stb_i),
    .we_i         (we_i),
    .adr_i        (adr_i),
    .dat_i        (dat_i),
    .sel_i        (sel_i),
    .dat_o        (dat_o),
    .ack_o        (ack_o),
    .sw_i         (sw_i),
    .led_o        (led_o),
    .seg_word_o   (seg_word),
    .fan_duty_o   (fan_duty),
    .push_o       (push),
    .push_data_o  (push_data),
    .fifo_count_i (fifo_count),
    .uart_busy_i  (uart_busy)
  );

  tx_fifo #(.DEPTH_LOG2(`IO_FIFO_DEPTH_LOG2)) tx_fifo_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .rd_data_o   (fifo_head),
    .empty_o     (fifo_empty),
    .count_o     (fifo_count)
  );

  uart_tx #(.CLKS_PER_BIT(`IO_BAUD_DIV)) uart_tx_i (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .empty_i (fifo_empty),
    .data_i  (fifo_head),
    .pop_o   (pop),
    .busy_o  (uart_busy),
    .tx_o    (tx_o)
  );

  fan_pwm fan_pwm_i (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .duty_i (fan_duty),
    .fan_o  (fan_o)
  );

  seg_decoder seg_decoder_i (
    .word_i (seg_word),
    .hex0_o (hex0_o),
    .hex1_o (hex1_o),
    .hex2_o (hex2_o),
    .hex3_o (hex3_o),
    .hex4_o (hex4_o),
    .hex5_o (hex5_o),
    .hex6_o (hex6_o),
    .hex7_o (hex7_o)
  );

endmodule

`default_nettype wire

// ==== rtl/seg_decoder.sv ====
`default_nettype none

module seg_decoder (
  input  io_pkg::io_word_t word_i,
  output io_pkg::seg_t     hex0_o,
  output io_pkg::seg_t     hex1_o,
  output io_pkg::seg_t     hex2_o,
  output io_pkg::seg_t     hex3_o,
  output io_pkg::seg_t     hex4_o,
  output io_pkg::seg_t     hex5_o,
  output io_pkg::seg_t     hex6_o,
  output io_pkg::seg_t     hex7_o
);

  import io_pkg::*;

  // Active low, bit 6 is g
  function automatic seg_t hex_to_seg(input logic [3:0] nib);
    case (nib)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'ha: return 7'h08;
      4'hb: return 7'h03;
      4'hc: return 7'h46;
      4'hd: return 7'h21;
      4'he: return 7'h06;
      default: return 7'h0e;                // F
    endcase
  endfunction

  assign hex0_o = hex_to_seg(word_i[3:0]);   // Lowest nibble
  assign hex1_o = hex_to_seg(word_i[7:4]);
  assign hex2_o = hex_to_seg(word_i[11:8]);
  assign hex3_o = hex_to_seg(word_i[15:12]);
  assign hex4_o = hex_to_seg(word_i[19:16]);
  assign hex5_o = hex_to_seg(word_i[23:20]);
  assign hex6_o = hex_to_seg(word_i[27:24]);
  assign hex7_o = hex_to_seg(word_i[31:28]);

endmodule

`default_nettype wire

// ==== rtl/tx_fifo.sv ====
`default_nettype none

module tx_fifo #(
  parameter int unsigned DEPTH_LOG2 = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  push_i,
  input  io_pkg::io_byte_t      push_data_i,
  input  logic                  pop_i,
  output io_pkg::io_byte_t      rd_data_o,
  output logic                  empty_o,
  output logic [DEPTH_LOG2:0]   count_o
);

  import io_pkg::*;

  localparam int unsigned DEPTH = 1 << DEPTH_LOG2;

  io_byte_t              mem_q [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr_q;
  logic [DEPTH_LOG2-1:0] rd_ptr_q;

  assign rd_data_o = mem_q[rd_ptr_q];       // Head shown ahead of pop
  assign empty_o   = (count_o == '0);

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_o  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;        // Wraps at DEPTH
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: ;                          // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_tx.sv ====
`default_nettype none

module uart_tx #(
  parameter int unsigned CLKS_PER_BIT = 8
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             empty_i,
  input  io_pkg::io_byte_t data_i,
  output logic             pop_o,
  output logic             busy_o,
  output logic             tx_o
);

  import io_pkg::*;

  localparam int unsigned CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  uart_state_e      state_q;
  logic [CNT_W-1:0] clk_cnt_q;
  logic [2:0]       bit_idx_q;
  io_byte_t         shift_q;
  logic             bit_done;

  assign bit_done = (clk_cnt_q == CNT_LAST);
  // Pop from idle, or at the end of a stop bit for back-to-back frames
  assign pop_o  = !empty_i && ((state_q == UART_IDLE) || (state_q == UART_STOP && bit_done));
  assign busy_o = (state_q != UART_IDLE);

  always_comb begin
    case (state_q)
      UART_START: tx_o = 1'b0;
      UART_DATA:  tx_o = shift_q[0];        // LSB first
      default:    tx_o = 1'b1;              // Idle line and stop bit
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q   <= UART_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
    end else begin
      if (state_q == UART_IDLE || bit_done) begin
        clk_cnt_q <= '0;
      end else begin
        clk_cnt_q <= clk_cnt_q + 1'b1;
      end
      case (state_q)
        UART_IDLE: begin
          if (pop_o) begin
            state_q <= UART_START;
          end
        end
        UART_START: begin
          if (bit_done) begin
            state_q   <= UART_DATA;
            bit_idx_q <= '0;
          end
        end
        UART_DATA: begin
          if (bit_done) begin
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) begin
              state_q <= UART_STOP;
            end
          end
        end
        UART_STOP: begin
          if (bit_done) begin
            state_q <= pop_o ? UART_START : UART_IDLE;
          end
        end
        default: state_q <= UART_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      shift_q <= data_i;
    end else if (state_q == UART_DATA && bit_done) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

endmodule

`default_nettype wire

// ==== test/io_top_properties.sv ====
`default_nettype none

`include "io_defines.svh"

module io_top_properties (
  input logic                         clk_i,
  input logic                         rst_i,
  input logic                         cyc_i,
  input logic                         stb_i,
  input logic                         ack_i,
  input logic                         push_i,
  input logic [`IO_FIFO_DEPTH_LOG2:0] fifo_count_i,
  input logic                         tx_i
);

  localparam int unsigned FIFO_DEPTH = 1 << `IO_FIFO_DEPTH_LOG2;

  ack_single_cycle: assert property (
    @(posedge clk_i) disable iff (rst_i) ack_i |=> !ack_i
  ) else $error("ack_o held high for two cycles");

  // Master drops stb_i on the falling edge after ack, so look one edge back
  ack_in_cycle: assert property (
    @(posedge clk_i) disable iff (rst_i) $rose(ack_i) |-> $past(cyc_i && stb_i)
  ) else $error("ack_o rose outside an active bus cycle");

  push_not_full: assert property (
    @(posedge clk_i) disable iff (rst_i) push_i |-> (fifo_count_i < FIFO_DEPTH)
  ) else $error("FIFO push while the count is at the depth");

  tx_idle_after_reset: assert property (
    @(posedge clk_i) $fell(rst_i) |-> tx_i
  ) else $error("tx_o not high after reset");

endmodule

bind io_top io_top_properties io_top_properties_i (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .cyc_i        (cyc_i),
  .stb_i        (stb_i),
  .ack_i        (ack_o),
  .push_i       (push),
  .fifo_count_i (fifo_count),
  .tx_i         (tx_o)
);

`default_nettype wire

// ==== test/io_top_stimulus.txt ====
# op addr data value, hex; W: value is byte selects, T: value is ack latency, 0 = held off
# R read word, S segment word, F fan high cycles, U serial byte, X sets switches from data
R 0000 00000000 00000000
S 0000 00000000 00000000
W 0000 76543210 f
S 0000 00000000 76543210
W 0000 fedcba98 5
R 0000 00000000 76dc3298
S 0000 00000000 76dc3298
W 0000 aabbccdd a
R 0000 00000000 aadccc98
S 0000 00000000 aadccc98
W 0000 fedcba98 f
S 0000 00000000 fedcba98
R 0001 00000000 00000020
F 0001 00000000 00000020
W 0001 ffffff95 f
R 0001 00000000 00000015
F 0001 00000000 00000015
W 0001 00000040 f
R 0001 00000000 00000040
F 0001 00000000 00000040
W 0001 00000000 f
F 0001 00000000 00000000
X 0000 0000a5c3 00000000
R 1000 00000000 0000a5c3
W 1000 000003a5 f
W 1000 fffffe00 f
R 3000 00000000 00000000
W 5004 ffffffff f
R 5004 00000000 00000000
R f000 00000000 00000000
T 2000 00000041 2
T 2000 00000042 2
T 2000 00000043 2
R 2000 00000000 00000201
U 2000 00000000 41
U 2000 00000000 42
U 2000 00000000 43
T 2000 00000010 2
T 2000 00000011 2
T 2000 00000012 2
T 2000 00000013 2
T 2000 00000014 2
R 2000 00000000 00000403
T 2000 00000015 0
U 2000 00000000 10
U 2000 00000000 11
U 2000 00000000 12
U 2000 00000000 13
U 2000 00000000 14
U 2000 00000000 15

// ==== test/io_top_tb.sv ====
`default_nettype none

`include "io_defines.svh"

module io_top_tb;

  import io_pkg::*;

  logic         clk_i;
  logic         rst_i;
  logic         cyc_i;
  logic         stb_i;
  logic         we_i;
  io_addr_t     adr_i;
  io_word_t     dat_i;
  io_byte_sel_t sel_i;
  io_word_t     dat_o;
  logic         ack_o;
  sw_t          sw_i;
  led_t         led_o;
  logic         tx_o;
  logic         fan_o;
  seg_t         hex_o [8];

  logic [63:0]  op_q [$];
  io_word_t     adr_q [$];
  io_word_t     dat_q [$];
  io_word_t     val_q [$];
  io_byte_t     rx_q [$];                   // Bytes seen on tx_o
  int           cycles = 0;
  int           limit = 0;

  io_top io_top_i (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .cyc_i  (cyc_i),
    .stb_i  (stb_i),
    .we_i   (we_i),
    .adr_i  (adr_i),
    .dat_i  (dat_i),
    .sel_i  (sel_i),
    .dat_o  (dat_o),
    .ack_o  (ack_o),
    .sw_i   (sw_i),
    .led_o  (led_o),
    .tx_o   (tx_o),
    .fan_o  (fan_o),
    .hex0_o (hex_o[0]),
    .hex1_o (hex_o[1]),
    .hex2_o (hex_o[2]),
    .hex3_o (hex_o[3]),
    .hex4_o (hex_o[4]),
    .hex5_o (hex_o[5]),
    .hex6_o (hex_o[6]),
    .hex7_o (hex_o[7])
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      abort_run($sformatf("Timeout after %0d cycles, the DUT stopped making progress", cycles));
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_word(input io_word_t act, input io_word_t exp, input string what);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0t: %s expected %h got %h", $time, what, exp, act));
    end
  endtask

  task automatic check_byte(input io_byte_t act, input io_byte_t exp);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0t: serial byte expected %h got %h", $time, exp, act));
    end
  endtask

  task automatic check_seg(input seg_t act, input seg_t exp, input string what);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0t: %s expected %h got %h", $time, what, exp, act));
    end
  endtask

  task automatic check_led(input led_t act, input led_t exp);
    if (act !== exp) begin
      abort_run($sformatf("** Error at %0t: led_o expected %h got %h", $time, exp, act));
    end
  endtask

  // Hex digit shapes, inverted for the active-low display
  function automatic seg_t expected_seg(input logic [3:0] digit);
    logic [6:0] lit;                        // Lit segments, g down to a
    case (digit)
      4'h0: lit = 7'b0111111;
      4'h1: lit = 7'b0000110;
      4'h2: lit = 7'b1011011;
      4'h3: lit = 7'b1001111;
      4'h4: lit = 7'b1100110;
      4'h5: lit = 7'b1101101;
      4'h6: lit = 7'b1111101;
      4'h7: lit = 7'b0000111;
      4'h8: lit = 7'b1111111;
      4'h9: lit = 7'b1101111;
      4'ha: lit = 7'b1110111;
      4'hb: lit = 7'b1111100;
      4'hc: lit = 7'b0111001;
      4'hd: lit = 7'b1011110;
      4'he: lit = 7'b1111001;
      default: lit = 7'b1110001;
    endcase
    return ~lit;
  endfunction

  task automatic read_stimulus(output int n_bytes);
    int            fd;
    int            code;
    logic [1023:0] line;
    logic [63:0]   op;
    io_word_t      adr;
    io_word_t      dat;
    io_word_t      val;
    n_bytes = 0;
    fd = $fopen("test/io_top_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open the stimulus file test/io_top_stimulus.txt");
    end
    while (!$feof(fd)) begin
      op = '0;
      code = $fscanf(fd, "%s", op);
      if (code == 1) begin
        if (op == "#") begin
          code = $fgets(line, fd);          // Rest of a comment line
        end else begin
          code = $fscanf(fd, "%h %h %h", adr, dat, val);
          if (code != 3) begin
            abort_run("A stimulus line has fewer than four columns");
          end
          op_q.push_back(op);
          adr_q.push_back(adr);
          dat_q.push_back(dat);
          val_q.push_back(val);
          if (op == "U") begin
            n_bytes++;
          end
        end
      end
    end
    $fclose(fd);
  endtask

  // Starts and ends just after a falling edge
  task automatic bus_access(input logic we, input io_word_t adr, input io_word_t dat,
                            input io_byte_sel_t sel, output io_word_t rdata,
                            output int lat);
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = we;
    adr_i = adr[15:0];
    dat_i = dat;
    sel_i = sel;
    @(posedge clk_i);                       // Sampling edge
    lat = 0;
    do begin
      @(posedge clk_i);
      lat++;
      @(negedge clk_i);
    end while (ack_o !== 1'b1);
    rdata = dat_o;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
    @(negedge clk_i);
  endtask

  // Samples each bit at its middle on falling edges
  task automatic watch_serial();
    io_byte_t rx;
    int       i;
    forever begin
      @(negedge clk_i);
      if (tx_o === 1'b0) begin
        repeat (`IO_BAUD_DIV / 2) @(negedge clk_i);
        if (tx_o !== 1'b0) begin
          abort_run("Start bit on tx_o ended early");
        end
        for (i = 0; i < 8; i++) begin
          repeat (`IO_BAUD_DIV) @(negedge clk_i);
          rx[i] = tx_o;
        end
        repeat (`IO_BAUD_DIV) @(negedge clk_i);
        if (tx_o !== 1'b1) begin
          abort_run("Stop bit missing on tx_o");
        end
        rx_q.push_back(rx);
      end
    end
  endtask

  task automatic run_op(input int n);
    io_word_t rdata;
    io_word_t adr;
    io_word_t dat;
    io_word_t val;
    int       lat;
    int       high_cnt;
    int       k;
    adr = adr_q[n];
    dat = dat_q[n];
    val = val_q[n];
    case (op_q[n])
      "W": begin
        bus_access(1'b1, adr, dat, val[3:0], rdata, lat);
        check_word(io_word_t'(lat), 32'd2, "write ack latency");
        if (adr[15:12] == `IO_PAGE_SWLED) begin
          check_led(led_o, dat[8:0]);
        end
      end
      "T": begin
        bus_access(1'b1, adr, dat, 4'h1, rdata, lat);
        if (val == 0) begin                 // Full FIFO, must be held off
          if (lat <= 2) begin
            abort_run("A UART write to a full FIFO was acknowledged without waiting");
          end
        end else begin
          check_word(io_word_t'(lat), val, "UART write ack latency");
        end
      end
      "R": begin
        bus_access(1'b0, adr, 32'h0, 4'hf, rdata, lat);
        check_word(io_word_t'(lat), 32'd2, "read ack latency");
        check_word(rdata, val, $sformatf("read of address %h", adr[15:0]));
      end
      "F": begin
        high_cnt = 0;
        repeat (1 << `IO_PWM_BITS) begin
          @(negedge clk_i);
          if (fan_o) begin
            high_cnt++;
          end
        end
        check_word(io_word_t'(high_cnt), val, "fan_o high cycles per period");
      end
      "S": begin
        for (k = 0; k < 8; k++) begin
          check_seg(hex_o[k], expected_seg(val[4*k +: 4]), $sformatf("hex%0d_o", k));
        end
      end
      "U": begin
        while (rx_q.size() == 0) begin
          @(posedge clk_i);
        end
        @(negedge clk_i);
        check_byte(rx_q.pop_front(), val[7:0]);
      end
      "X": begin
        sw_i = dat[15:0];
        @(negedge clk_i);
      end
      default: abort_run("Unknown opcode in the stimulus file");
    endcase
  endtask

  initial begin
    int n_bytes;
    clk_i = 1'b0;
    rst_i = 1'b1;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
    adr_i = '0;
    dat_i = '0;
    sel_i = '0;
    sw_i  = '0;
    read_stimulus(n_bytes);
    limit = op_q.size() * 40 + n_bytes * 12 * `IO_BAUD_DIV;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    fork
      watch_serial();
    join_none
    foreach (op_q[n]) begin
      run_op(n);
    end
    repeat (12 * `IO_BAUD_DIV) @(negedge clk_i);   // Room for a duplicate to show up
    if (rx_q.size() != 0) begin
      abort_run("An extra byte arrived on tx_o");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

`default_nettype wire
